// File: design/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int IMEM_DEPTH = 256;                // Program words
    localparam int PC_W       = $clog2(IMEM_DEPTH); // 8-bit pc, wraps at the top
    localparam int INSTR_W    = 9;                  // Instruction word width
    localparam int IMM_W      = 6;                  // ra, rb, lo packed together

    localparam logic [1:0] REG_ACC = 2'd1;          // r1 takes ALU and LDI results

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,                             // r1 = ra + rb
        OP_SUB  = 3'd1,                             // r1 = ra - rb
        OP_DONE = 3'd2,                             // Stop the run
        OP_AND  = 3'd3,                             // r1 = ra & rb
        OP_LDI  = 3'd4,                             // r1 = zero-extended imm6
        OP_LD   = 3'd5,                             // rb = mem[ra]
        OP_ST   = 3'd6,                             // mem[ra] = rb
        OP_BZ   = 3'd7                              // pc += signed imm6 when r1 is zero
    } opcode_e;

    // Bit 8 down to bit 0
    typedef struct packed {
        opcode_e    opcode;                         // [8:6]
        logic [1:0] ra;                             // [5:4] also imm6[5:4]
        logic [1:0] rb;                             // [3:2] also imm6[3:2]
        logic [1:0] lo;                             // [1:0] imm6[1:0] only
    } instr_t;

endpackage

`default_nettype wire

// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int DATA_W      = 8;                    // Register and memory word width
    localparam int DMEM_DEPTH  = 256;                  // Whole register value as address
    localparam int DADDR_W     = $clog2(DMEM_DEPTH);   // 8 address bits
    localparam int CYCLE_W     = 16;                   // Cycle counter width
    localparam int CYCLE_LIMIT = 4096;                 // Forced stop after this many cycles

    typedef enum logic [1:0] {
        ALU_ADD,                                       // a + b, modulo 256
        ALU_SUB,                                       // a - b, modulo 256
        ALU_AND,                                       // Bitwise and
        ALU_PASS_B                                     // b unchanged
    } alu_op_e;

    typedef enum logic {
        DEST_ACC,                                      // Write-back to r1
        DEST_RB                                        // Write-back to rb field
    } dest_e;

    // All-zero value is a harmless no-op
    typedef struct packed {
        alu_op_e             alu_op;                   // ALU function
        logic                use_imm;                  // Operands are 0 and imm
        logic                reg_we;                   // Register write-back
        dest_e               dest_sel;                 // r1 or rb
        logic                mem_read;                 // Write-back from data memory
        logic                mem_write;                // Store rb to mem[ra]
        logic                branch;                   // BZ
        logic                halt;                     // DONE
        logic [DATA_W-1:0]   imm;                      // Already extended
        logic [1:0]          ra;                       // Read port A index
        logic [1:0]          rb;                       // Read port B index
    } ctrl_t;

    typedef struct packed {
        logic [DATA_W-1:0]   alu_out;                  // ALU result
        logic                branch_taken;             // BZ with r1 zero
        logic [DADDR_W-1:0]  mem_addr;                 // Address from ra
        logic [DATA_W-1:0]   store_data;               // Data from rb
    } exec_t;

endpackage

`default_nettype wire

// File: design/word_ram.sv
`timescale 1ns/1ps
`default_nettype none

module word_ram #(
    parameter type word_t = logic [7:0],             // Payload of one word
    parameter int  DEPTH  = 256                      // Number of words
) (
    input  wire logic                     clk,
    input  wire logic                     we,        // Write strobe
    input  wire logic [$clog2(DEPTH)-1:0] waddr,
    input  wire word_t                    wdata,
    input  wire logic [$clog2(DEPTH)-1:0] raddr,
    output      word_t                    rdata      // Combinational read
);

    word_t mem [DEPTH];                              // Storage, contents survive reset

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;                     // Visible after the edge
        end
    end

    // Async read so fetch and LD see the word in the same cycle
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import isa_pkg::*, core_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                start,         // Host level, run begins on its fall
    input  wire logic                halt,          // DONE being executed
    input  wire logic                branch_taken,  // BZ condition met
    input  wire logic [DATA_W-1:0]   branch_off,    // Sign-extended offset
    output      logic [PC_W-1:0]     pc,
    output      logic                running,
    output      logic                done,
    output      logic [CYCLE_W-1:0]  cycles
);

    logic                armed;                     // start seen high since last launch
    logic                launch;                    // Begin a run at this edge
    logic                limit_hit;                 // This cycle is the last allowed one
    logic [PC_W-1:0]     next_pc;
    logic [CYCLE_W-1:0]  cycles_next;

    assign launch      = armed && !start && !running;
    assign cycles_next = cycles + 1'b1;
    assign limit_hit   = (cycles_next == CYCLE_W'(CYCLE_LIMIT));

    // Relative branch, plain increment otherwise; both wrap
    assign next_pc = branch_taken ? pc + branch_off : pc + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            armed   <= 1'b0;
            running <= 1'b0;
            done    <= 1'b0;
            pc      <= '0;
            cycles  <= '0;
        end else begin
            if (start && !running) begin
                armed <= 1'b1;                      // Wait for start to drop
            end else if (launch) begin
                armed <= 1'b0;                      // One run per start pulse
            end

            if (launch) begin
                running <= 1'b1;
                done    <= 1'b0;                    // Cleared only by a new run
                pc      <= '0;                      // Always from address 0
                cycles  <= '0;
            end else if (running) begin
                pc     <= next_pc;
                cycles <= cycles_next;              // DONE cycle counted too
                if (halt || limit_hit) begin
                    running <= 1'b0;
                    done    <= 1'b1;                // Held until next launch
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
    import isa_pkg::*, core_pkg::*;
(
    input  wire instr_t  instr,                     // From instruction memory
    input  wire logic    running,
    output      ctrl_t   ctrl
);

    logic [IMM_W-1:0] imm6;                         // Raw immediate field

    assign imm6 = {instr.ra, instr.rb, instr.lo};

    always_comb begin
        ctrl = '0;                                  // Idle core, no writes, no halt
        if (running) begin
            ctrl.ra       = instr.ra;
            ctrl.rb       = instr.rb;
            ctrl.alu_op   = ALU_PASS_B;             // Don't care for non-ALU ops
            ctrl.dest_sel = DEST_ACC;
            case (instr.opcode)
                OP_ADD: begin
                    ctrl.alu_op = ALU_ADD;
                    ctrl.reg_we = 1'b1;             // Into r1
                end
                OP_SUB: begin
                    ctrl.alu_op = ALU_SUB;
                    ctrl.reg_we = 1'b1;
                end
                OP_AND: begin
                    ctrl.alu_op = ALU_AND;
                    ctrl.reg_we = 1'b1;
                end
                OP_LDI: begin
                    ctrl.alu_op  = ALU_ADD;         // 0 + imm
                    ctrl.use_imm = 1'b1;
                    ctrl.reg_we  = 1'b1;
                    ctrl.imm     = {{(DATA_W-IMM_W){1'b0}}, imm6}; // Zero-extend
                end
                OP_LD: begin
                    ctrl.mem_read = 1'b1;
                    ctrl.reg_we   = 1'b1;
                    ctrl.dest_sel = DEST_RB;        // Only LD targets rb
                end
                OP_ST: begin
                    ctrl.mem_write = 1'b1;
                end
                OP_BZ: begin
                    ctrl.branch = 1'b1;
                    ctrl.imm    = {{(DATA_W-IMM_W){imm6[IMM_W-1]}}, imm6}; // Sign-extend
                end
                OP_DONE: begin
                    ctrl.halt = 1'b1;
                end
                default: ctrl = '0;                 // Unreachable with 3-bit opcode
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import core_pkg::*;
(
    input  wire ctrl_t              ctrl,
    input  wire logic [DATA_W-1:0]  data_a,          // Register at ra
    input  wire logic [DATA_W-1:0]  data_b,          // Register at rb
    input  wire logic [DATA_W-1:0]  data_acc,        // r1, branch condition
    output      exec_t              ex
);

    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] alu_res;

    // LDI turns the ALU into 0 + imm
    assign op_a = ctrl.use_imm ? '0 : data_a;
    assign op_b = ctrl.use_imm ? ctrl.imm : data_b;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;       // Wraps modulo 256
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_b;
        endcase
    end

    always_comb begin
        ex              = '0;
        ex.alu_out      = alu_res;
        ex.branch_taken = ctrl.branch && (data_acc == '0); // BZ tests r1 only
        ex.mem_addr     = data_a;                    // LD and ST address by ra
        ex.store_data   = data_b;                    // ST source is rb
    end

endmodule

`default_nettype wire

// File: design/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage
    import isa_pkg::*, core_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                running,       // Core owns the data memory
    input  wire ctrl_t               ctrl,
    input  wire exec_t               ex,
    output      logic [DATA_W-1:0]   data_a,
    output      logic [DATA_W-1:0]   data_b,
    output      logic [DATA_W-1:0]   data_acc,
    input  wire logic                host_we,       // Host write strobe
    input  wire logic [DADDR_W-1:0]  host_addr,
    input  wire logic [DATA_W-1:0]   host_wdata,
    output      logic [DATA_W-1:0]   host_rdata     // Combinational read-back
);

    logic [DATA_W-1:0]   regs [4];                  // r0 to r3
    logic [1:0]          wr_idx;                    // Write-back register
    logic [DATA_W-1:0]   wb_data;                   // Write-back value
    logic [DATA_W-1:0]   mem_rdata;
    logic [DADDR_W-1:0]  mem_addr;
    logic [DATA_W-1:0]   mem_wdata;
    logic                mem_we;

    // Three combinational read ports
    assign data_a   = regs[ctrl.ra];
    assign data_b   = regs[ctrl.rb];
    assign data_acc = regs[REG_ACC];

    assign wr_idx  = (ctrl.dest_sel == DEST_RB) ? ctrl.rb : REG_ACC;
    assign wb_data = ctrl.mem_read ? mem_rdata : ex.alu_out; // LD takes memory data

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_we) begin
            regs[wr_idx] <= wb_data;                // ctrl is zero when idle
        end
    end

    // Host port locked out while the core runs
    assign mem_addr  = running ? ex.mem_addr : host_addr;
    assign mem_wdata = running ? ex.store_data : host_wdata;
    assign mem_we    = running ? ctrl.mem_write : host_we;

    word_ram #(
        .word_t (logic [DATA_W-1:0]),
        .DEPTH  (DMEM_DEPTH)
    ) u_dmem (
        .clk    (clk),
        .we     (mem_we),
        .waddr  (mem_addr),
        .wdata  (mem_wdata),
        .raddr  (mem_addr),                         // Shared address, async read
        .rdata  (mem_rdata)
    );

    assign host_rdata = mem_rdata;                  // Valid for host when idle

endmodule

`default_nettype wire

// File: design/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top
    import isa_pkg::*, core_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                start,          // Run on falling edge
    output      logic                done,
    output      logic [CYCLE_W-1:0]  cycles,         // Cycles of the last run
    input  wire logic                imem_we,        // Program load strobe
    input  wire logic [PC_W-1:0]     imem_addr,
    input  wire instr_t              imem_wdata,
    input  wire logic                dmem_we,        // Data load strobe
    input  wire logic [DADDR_W-1:0]  dmem_addr,
    input  wire logic [DATA_W-1:0]   dmem_wdata,
    output      logic [DATA_W-1:0]   dmem_rdata
);

    logic [PC_W-1:0]    pc;
    logic               running;
    instr_t             instr;
    ctrl_t              ctrl;
    exec_t              ex;
    logic [DATA_W-1:0]  data_a;
    logic [DATA_W-1:0]  data_b;
    logic [DATA_W-1:0]  data_acc;

    fetch_unit u_fetch (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .halt         (ctrl.halt),
        .branch_taken (ex.branch_taken),
        .branch_off   (ctrl.imm),                    // Sign-extended by decoder
        .pc           (pc),
        .running      (running),
        .done         (done),
        .cycles       (cycles)
    );

    word_ram #(
        .word_t (instr_t),
        .DEPTH  (IMEM_DEPTH)
    ) u_imem (
        .clk    (clk),
        .we     (imem_we && !running),               // No program writes mid-run
        .waddr  (imem_addr),
        .wdata  (imem_wdata),
        .raddr  (pc),
        .rdata  (instr)
    );

    instr_decoder u_dec (
        .instr   (instr),
        .running (running),
        .ctrl    (ctrl)
    );

    execute_stage u_exec (
        .ctrl     (ctrl),
        .data_a   (data_a),
        .data_b   (data_b),
        .data_acc (data_acc),
        .ex       (ex)
    );

    result_stage u_result (
        .clk        (clk),
        .reset      (reset),
        .running    (running),
        .ctrl       (ctrl),
        .ex         (ex),
        .data_a     (data_a),
        .data_b     (data_b),
        .data_acc   (data_acc),
        .host_we    (dmem_we),
        .host_addr  (dmem_addr),
        .host_wdata (dmem_wdata),
        .host_rdata (dmem_rdata)
    );

endmodule

`default_nettype wire

// File: testbench/core_tb_tasks.svh
`ifndef CORE_TB_TASKS_SVH
`define CORE_TB_TASKS_SVH

function automatic instr_t make_reg_instr(opcode_e op, logic [1:0] ra, logic [1:0] rb);
    return {op, ra, rb, 2'b00};                     // lo field unused
endfunction

function automatic instr_t make_imm_instr(opcode_e op, logic [IMM_W-1:0] imm);
    return {op, imm};                               // imm6 spans ra, rb, lo
endfunction

// ISA reference model running prog_img on model_mem and model_regs
task automatic run_model(output int n);
    logic [PC_W-1:0]   pc;
    logic [PC_W-1:0]   pc_next;
    instr_t            ins;
    logic [IMM_W-1:0]  imm6;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    bit                halted;
    pc     = '0;
    n      = 0;
    halted = 1'b0;
    while (!halted) begin
        ins     = prog_img[pc];
        imm6    = {ins.ra, ins.rb, ins.lo};
        a       = model_regs[ins.ra];
        b       = model_regs[ins.rb];
        pc_next = pc + 8'd1;
        n++;                                        // DONE counts as a cycle
        case (ins.opcode)
            OP_ADD:  model_regs[1] = a + b;
            OP_SUB:  model_regs[1] = a - b;
            OP_AND:  model_regs[1] = a & b;
            OP_LDI:  model_regs[1] = {2'b00, imm6};
            OP_LD:   model_regs[ins.rb] = model_mem[a];
            OP_ST:   model_mem[a] = b;
            OP_BZ:   if (model_regs[1] == 8'd0) pc_next = pc + {{2{imm6[5]}}, imm6};
            default: halted = 1'b1;                 // OP_DONE
        endcase
        pc = pc_next;
        if (n == CYCLE_LIMIT) halted = 1'b1;        // Forced stop
    end
endtask

// r2 and r3 filled through memory, then each ALU result stored
task automatic build_alu_program(logic [IMM_W-1:0] a, logic [IMM_W-1:0] b);
    prog_q.push_back(make_imm_instr(OP_LDI, a));
    prog_q.push_back(make_reg_instr(OP_ST, 2'd0, 2'd1));   // mem[r0] = r1
    prog_q.push_back(make_reg_instr(OP_LD, 2'd0, 2'd2));   // r2 = a
    prog_q.push_back(make_imm_instr(OP_LDI, b));
    prog_q.push_back(make_reg_instr(OP_ST, 2'd0, 2'd1));
    prog_q.push_back(make_reg_instr(OP_LD, 2'd0, 2'd3));   // r3 = b
    prog_q.push_back(make_reg_instr(OP_ADD, 2'd2, 2'd3));
    prog_q.push_back(make_reg_instr(OP_ST, 2'd2, 2'd1));   // Sum at mem[a]
    prog_q.push_back(make_reg_instr(OP_SUB, 2'd2, 2'd3));
    prog_q.push_back(make_reg_instr(OP_ST, 2'd3, 2'd1));   // Difference at mem[b]
    prog_q.push_back(make_reg_instr(OP_AND, 2'd2, 2'd3));
    prog_q.push_back(make_reg_instr(OP_ST, 2'd0, 2'd1));
    prog_q.push_back(make_reg_instr(OP_DONE, 2'd0, 2'd0));
endtask

task automatic reset_and_hold();
    assert (!done) else report_mismatch("done after reset", int'(done), 0);
    assert (cycles == '0) else report_mismatch("cycles after reset", int'(cycles), 0);
    for (int a = 0; a < DMEM_DEPTH; a++) begin
        write_data(DADDR_W'(a), DATA_W'($urandom), 1'b1);
    end
    prog_q.push_back(make_reg_instr(OP_DONE, 2'd0, 2'd0));
    load_program();
    dmem_addr = DADDR_W'($urandom);                 // Word watched while start is held
    run_and_check(20, 1'b1);
    finish_test("reset and hold");
endtask

task automatic alu_ops();
    build_alu_program(IMM_W'($urandom), IMM_W'($urandom));
    load_program();
    run_and_check(1, 1'b0);
    finish_test("alu instructions");
endtask

task automatic load_store_copy();
    logic [IMM_W-1:0] src [2];
    logic [IMM_W-1:0] dst [2];
    for (int i = 0; i < 2; i++) begin
        src[i] = IMM_W'($urandom % 32);             // Sources low, destinations high
        dst[i] = IMM_W'(32 + $urandom % 32);
        write_data({2'b00, src[i]}, DATA_W'($urandom), 1'b1);
        prog_q.push_back(make_imm_instr(OP_LDI, src[i]));
        prog_q.push_back(make_reg_instr(OP_LD, 2'd1, 2'(2 + i)));   // r2 or r3 = mem[src]
        prog_q.push_back(make_imm_instr(OP_LDI, dst[i]));
        prog_q.push_back(make_reg_instr(OP_ST, 2'd1, 2'(2 + i)));
    end
    prog_q.push_back(make_reg_instr(OP_DONE, 2'd0, 2'd0));
    load_program();
    run_and_check(1, 1'b0);
    finish_test("load and store");
endtask

// r0 = 1 as address and decrement, r2 counter, r3 running sum
task automatic branch_countdown();
    int                n;
    logic [DATA_W-1:0] got;
    n = 1 + $urandom % 15;
    prog_q.push_back(make_imm_instr(OP_LDI, 6'd1));
    prog_q.push_back(make_reg_instr(OP_ST, 2'd1, 2'd1));
    prog_q.push_back(make_reg_instr(OP_LD, 2'd1, 2'd0));       // r0 = 1
    prog_q.push_back(make_imm_instr(OP_LDI, IMM_W'(n)));
    prog_q.push_back(make_reg_instr(OP_ST, 2'd0, 2'd1));
    prog_q.push_back(make_reg_instr(OP_LD, 2'd0, 2'd2));       // r2 = n
    prog_q.push_back(make_imm_instr(OP_LDI, 6'd0));
    prog_q.push_back(make_reg_instr(OP_ST, 2'd0, 2'd1));
    prog_q.push_back(make_reg_instr(OP_LD, 2'd0, 2'd3));       // r3 = 0
    prog_q.push_back(make_reg_instr(OP_AND, 2'd2, 2'd2));      // 9: r1 = counter
    prog_q.push_back(make_imm_instr(OP_BZ, 6'd9));             // Forward exit to 19
    prog_q.push_back(make_reg_instr(OP_ADD, 2'd3, 2'd2));
    prog_q.push_back(make_reg_instr(OP_ST, 2'd0, 2'd1));
    prog_q.push_back(make_reg_instr(OP_LD, 2'd0, 2'd3));       // r3 += r2
    prog_q.push_back(make_reg_instr(OP_SUB, 2'd2, 2'd0));
    prog_q.push_back(make_reg_instr(OP_ST, 2'd0, 2'd1));
    prog_q.push_back(make_reg_instr(OP_LD, 2'd0, 2'd2));       // r2 -= 1
    prog_q.push_back(make_imm_instr(OP_LDI, 6'd0));
    prog_q.push_back(make_imm_instr(OP_BZ, 6'(-9)));           // Back to 9
    prog_q.push_back(make_reg_instr(OP_ST, 2'd0, 2'd3));       // mem[1] = sum
    prog_q.push_back(make_reg_instr(OP_DONE, 2'd0, 2'd0));
    load_program();
    run_and_check(1, 1'b0);
    read_data(8'd1, got);
    assert (got == DATA_W'(n * (n + 1) / 2))
        else report_mismatch("sum", int'(got), n * (n + 1) / 2);
    finish_test("branches");
endtask

task automatic cycle_limit_run();
    logic [DADDR_W-1:0] addr;
    int                 exp_cycles;
    addr = DADDR_W'($urandom);
    prog_q.push_back(make_imm_instr(OP_LDI, 6'd0));
    prog_q.push_back(make_imm_instr(OP_BZ, 6'd0));             // Spins at pc 1
    load_program();
    start_run(1, 1'b0);
    write_instr(8'd1, make_reg_instr(OP_DONE, 2'd0, 2'd0));    // Would halt if accepted
    write_data(addr, ~model_mem[addr], 1'b0);
    wait_done();
    if (!timed_out) begin
        assert (cycles == CYCLE_W'(CYCLE_LIMIT))
            else report_mismatch("cycles at limit", int'(cycles), CYCLE_LIMIT);
        run_model(exp_cycles);
        check_run(exp_cycles);
    end
    finish_test("cycle limit");
endtask

task automatic restart_run();
    build_alu_program(IMM_W'($urandom), IMM_W'($urandom));
    load_program();
    run_and_check(1, 1'b0);
    run_and_check(1, 1'b0);                         // Same program, done high beforehand
    finish_test("restart");
endtask

`endif

// File: testbench/tb_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_top
    import isa_pkg::*, core_pkg::*;
();

    logic                clk;
    logic                reset;
    logic                start;
    logic                done;
    logic [CYCLE_W-1:0]  cycles;
    logic                imem_we;
    logic [PC_W-1:0]     imem_addr;
    instr_t              imem_wdata;
    logic                dmem_we;
    logic [DADDR_W-1:0]  dmem_addr;
    logic [DATA_W-1:0]   dmem_wdata;
    logic [DATA_W-1:0]   dmem_rdata;

    instr_t              prog_q [$];                // Program being built
    instr_t              prog_img [IMEM_DEPTH];     // Copy of the instruction memory
    logic [DATA_W-1:0]   model_mem [DMEM_DEPTH];    // Expected data memory
    logic [DATA_W-1:0]   model_regs [4];            // Expected registers, kept across runs
    int                  test_errors;
    int                  tests_passed;
    int                  tests_failed;
    bit                  timed_out;

    core_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .done       (done),
        .cycles     (cycles),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

    task automatic report_mismatch(string what, int got, int exp);
        $display("MISMATCH at %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
        test_errors++;
    endtask

    task automatic write_instr(logic [PC_W-1:0] addr, instr_t ins);
        @(negedge clk);
        imem_we    = 1'b1;
        imem_addr  = addr;
        imem_wdata = ins;
        @(negedge clk);
        imem_we    = 1'b0;
    endtask

    // shadow set when the write is expected to land
    task automatic write_data(logic [DADDR_W-1:0] addr, logic [DATA_W-1:0] data, bit shadow);
        @(negedge clk);
        dmem_we    = 1'b1;
        dmem_addr  = addr;
        dmem_wdata = data;
        @(negedge clk);
        dmem_we    = 1'b0;
        if (shadow) model_mem[addr] = data;
    endtask

    task automatic read_data(logic [DADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        @(negedge clk);
        dmem_addr = addr;
        #1;                                         // Combinational read settles
        data = dmem_rdata;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_q.size(); i++) begin
            write_instr(PC_W'(i), prog_q[i]);
            prog_img[i] = prog_q[i];
        end
        prog_q.delete();
    endtask

    // Start held high for hold cycles and the run begins once it drops
    task automatic start_run(int hold, bit idle_check);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            start = 1'b1;
            if (idle_check) begin
                #1;
                assert (!done) else report_mismatch("done while start high", int'(done), 0);
                assert (dmem_rdata == model_mem[dmem_addr])
                    else report_mismatch("held dmem word", int'(dmem_rdata),
                                         int'(model_mem[dmem_addr]));
            end
        end
        @(negedge clk);
        start = 1'b0;
        @(negedge clk);
        assert (!done) else report_mismatch("done at run start", int'(done), 0);
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (!done && waited < CYCLE_LIMIT + 100) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("Timed out after %0d cycles waiting for done to rise", waited);
            test_errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_run(int exp_cycles);
        logic [DATA_W-1:0] got;
        assert (cycles == CYCLE_W'(exp_cycles))
            else report_mismatch("cycles", int'(cycles), exp_cycles);
        for (int a = 0; a < DMEM_DEPTH; a++) begin  // Whole memory against the model
            read_data(DADDR_W'(a), got);
            assert (got == model_mem[a])
                else report_mismatch($sformatf("dmem[%0d]", a), int'(got), int'(model_mem[a]));
        end
        assert (done) else report_mismatch("done held after run", int'(done), 1);
    endtask

    task automatic run_and_check(int hold, bit idle_check);
        int exp_cycles;
        start_run(hold, idle_check);
        wait_done();
        if (!timed_out) begin
            run_model(exp_cycles);
            check_run(exp_cycles);
        end
    endtask

    task automatic finish_test(string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

`include "core_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                      // 8 ns period
    end

    initial begin
        reset        = 1'b1;
        start        = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        dmem_we      = 1'b0;
        dmem_addr    = '0;
        dmem_wdata   = '0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        foreach (model_regs[i]) model_regs[i] = '0;  // Registers clear on reset
        void'($urandom(95808));
        repeat (2) @(negedge clk);
        reset = 1'b0;
        reset_and_hold();
        if (!timed_out) alu_ops();
        if (!timed_out) load_store_copy();
        if (!timed_out) branch_countdown();
        if (!timed_out) cycle_limit_run();
        if (!timed_out) restart_run();
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+testbench
design/isa_pkg.sv
design/core_pkg.sv
design/word_ram.sv
design/fetch_unit.sv
design/instr_decoder.sv
design/execute_stage.sv
design/result_stage.sv
design/core_top.sv
testbench/tb_core_top.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module tb_core_top -o tb_core_top_sim \
    && out=$(./obj_dir/tb_core_top_sim) \
    && echo "$out" \
    && echo "$out" | grep -q "TEST RESULT: PASS" \
    || { echo "Simulation did not pass"; exit 1; }
